// File: Makefile
# Verilator build of the bicubic resampler testbench

TOP           ?= tb_bicubic
FLIST         ?= flist.f
OBJ_DIR       ?= obj_dir
LOG           ?= sim.log
TIMEOUT_EXTRA ?= 0
VERILATOR     ?= verilator
VFLAGS        ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GTIMEOUT_EXTRA=$(TIMEOUT_EXTRA) \
		--Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: flist.f
hw/bicubic_pkg.sv
hw/frac_divider.sv
hw/cubic_engine.sv
hw/position_ctrl.sv
hw/bicubic_resampler.sv
sim/tb_checker.sv
sim/tb_bicubic.sv

// File: hw/bicubic_pkg.sv
`default_nettype none

package bicubic_pkg;

    localparam int PIX_W  = 8;
    localparam int FRAC_W = 8;   // Q0.8 fraction
    localparam int LEN_W  = 7;   // lengths up to 127

    typedef logic [PIX_W-1:0]  pix_t;
    typedef logic [FRAC_W-1:0] frac_t;

    // source taps around the current position
    // p0 = src[q-1], p1 = src[q], p2 = src[q+1], p3 = src[q+2]
    typedef struct packed {
        pix_t p0;
        pix_t p1;
        pix_t p2;
        pix_t p3;
    } win_t;

    // one job for the cubic engine
    typedef struct packed {
        win_t  win;
        frac_t frac;
    } cubic_req_t;

    // controller FSM
    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,  // waiting for start
        ST_FILL    = 3'd1,  // first taps from the stream
        ST_DIVIDE  = 3'd2,  // remainder to fraction
        ST_ISSUE   = 3'd3,  // hand the window to the engine
        ST_ADVANCE = 3'd4,  // step q/r, maybe shift window
        ST_DONE    = 3'd5   // all outputs issued
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: hw/bicubic_resampler.sv
`timescale 1ns/1ps
`default_nettype none

module bicubic_resampler #(
    parameter int LEN_W = bicubic_pkg::LEN_W
) (
    input  wire logic              CLK,
    input  wire logic              RST,
    input  wire logic              start_i,
    input  wire logic [LEN_W-1:0]  src_len_i,
    input  wire logic [LEN_W-1:0]  dst_len_i,
    input  wire logic              src_valid_i,
    input  wire bicubic_pkg::pix_t src_pix_i,
    output logic                   src_ready_o,
    output logic                   out_valid_o,
    output bicubic_pkg::pix_t      out_pix_o,
    input  wire logic              out_ready_i,
    output logic                   done_o
);
    import bicubic_pkg::*;

    logic             div_start;
    logic [LEN_W-1:0] div_rem;
    logic [LEN_W-1:0] div_den;
    logic             div_done;
    frac_t            div_frac;
    cubic_req_t       req;
    logic             req_valid;
    logic             req_ready;
    logic             last_issued;
    logic [2:0]       in_flight;  // engine holds at most five

    position_ctrl #(.LEN_W(LEN_W)) u_ctrl (
        .CLK           (CLK),
        .RST           (RST),
        .start_i       (start_i),
        .src_len_i     (src_len_i),
        .dst_len_i     (dst_len_i),
        .src_valid_i   (src_valid_i),
        .src_pix_i     (src_pix_i),
        .src_ready_o   (src_ready_o),
        .div_start_o   (div_start),
        .div_rem_o     (div_rem),
        .div_den_o     (div_den),
        .div_done_i    (div_done),
        .div_frac_i    (div_frac),
        .req_o         (req),
        .req_valid_o   (req_valid),
        .req_ready_i   (req_ready),
        .last_issued_o (last_issued)
    );

    frac_divider #(.LEN_W(LEN_W)) u_div (
        .CLK     (CLK),
        .RST     (RST),
        .start_i (div_start),
        .rem_i   (div_rem),
        .den_i   (div_den),
        .done_o  (div_done),
        .frac_o  (div_frac)
    );

    cubic_engine u_engine (
        .CLK         (CLK),
        .RST         (RST),
        .req_i       (req),
        .req_valid_i (req_valid),
        .req_ready_o (req_ready),
        .out_valid_o (out_valid_o),
        .out_pix_o   (out_pix_o),
        .out_ready_i (out_ready_i)
    );

    // requests inside the engine not yet taken downstream
    always_ff @(posedge CLK) begin
        if (RST) begin
            in_flight <= '0;
        end else begin
            case ({req_valid & req_ready, out_valid_o & out_ready_i})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;
            endcase
        end
    end

    assign done_o = last_issued && (in_flight == '0);  // last pixel has left

    // a stalled result holds until taken
    assert property (@(posedge CLK) disable iff (RST)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_pix_o))
        else $error("bicubic_resampler: output changed while stalled");

endmodule

`default_nettype wire

// File: hw/cubic_engine.sv
`timescale 1ns/1ps
`default_nettype none

module cubic_engine (
    input  wire logic                    CLK,
    input  wire logic                    RST,
    input  wire bicubic_pkg::cubic_req_t req_i,
    input  wire logic                    req_valid_i,
    output logic                         req_ready_o,
    output logic                         out_valid_o,
    output bicubic_pkg::pix_t            out_pix_o,
    input  wire logic                    out_ready_i
);
    import bicubic_pkg::*;

    localparam int ACC_W = 16;  // covers every Horner partial
    typedef logic signed [ACC_W-1:0] acc_t;

    localparam acc_t C2 = 2;
    localparam acc_t C3 = 3;
    localparam acc_t C4 = 4;
    localparam acc_t C5 = 5;
    localparam acc_t PIX_MAX = (1 << PIX_W) - 1;

    // floor(v * x / 256)
    function automatic acc_t horner_mul(input acc_t v, input frac_t x);
        logic signed [ACC_W+FRAC_W:0] prod;
        prod = v * $signed({1'b0, x});
        return acc_t'(prod >>> FRAC_W);
    endfunction

    logic       stage_en;
    logic [4:0] vld;        // one valid per stage, vld[4] at the output
    cubic_req_t s0_req;
    win_t       w;
    acc_t       e0, e1, e2, e3;
    acc_t       coef_a, coef_b, coef_c, coef_d;
    acc_t       st1_a, st1_b, st1_c, st1_d;
    acc_t       st2_h, st2_b, st2_c, st2_d;
    acc_t       st3_h, st3_c, st3_d;
    frac_t      st1_x, st2_x, st3_x;
    acc_t       s3;
    acc_t       rnd;
    pix_t       pix_next;

    assign stage_en    = !(vld[4] && !out_ready_i);  // whole pipe freezes
    assign req_ready_o = stage_en;
    assign out_valid_o = vld[4];

    // Catmull-Rom coefficients, doubled
    always_comb begin
        w      = s0_req.win;
        e0     = acc_t'(w.p0);
        e1     = acc_t'(w.p1);
        e2     = acc_t'(w.p2);
        e3     = acc_t'(w.p3);
        coef_a = C3 * (e1 - e2) + e3 - e0;
        coef_b = C2 * e0 - C5 * e1 + C4 * e2 - e3;
        coef_c = e2 - e0;
        coef_d = C2 * e1;
    end

    // last Horner step, halve and clamp
    always_comb begin
        s3  = horner_mul(st3_h + st3_c, st3_x);
        rnd = (s3 + st3_d + acc_t'(1)) >>> 1;
        if (rnd < 0) begin
            pix_next = '0;
        end else if (rnd > PIX_MAX) begin
            pix_next = '1;
        end else begin
            pix_next = pix_t'(rnd);
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            vld <= '0;
        end else if (stage_en) begin
            vld <= {vld[3:0], req_valid_i};
        end
    end

    always_ff @(posedge CLK) begin
        if (stage_en) begin
            s0_req    <= req_i;                       // stage 0
            st1_a     <= coef_a;                      // stage 1
            st1_b     <= coef_b;
            st1_c     <= coef_c;
            st1_d     <= coef_d;
            st1_x     <= s0_req.frac;
            st2_h     <= horner_mul(st1_a, st1_x);    // stage 2
            st2_b     <= st1_b;
            st2_c     <= st1_c;
            st2_d     <= st1_d;
            st2_x     <= st1_x;
            st3_h     <= horner_mul(st2_h + st2_b, st2_x);
            st3_c     <= st2_c;
            st3_d     <= st2_d;
            st3_x     <= st2_x;
            out_pix_o <= pix_next;                    // stage 4
        end
    end

endmodule

`default_nettype wire

// File: hw/frac_divider.sv
`timescale 1ns/1ps
`default_nettype none

module frac_divider #(
    parameter int LEN_W = bicubic_pkg::LEN_W
) (
    input  wire logic             CLK,
    input  wire logic             RST,
    input  wire logic             start_i,
    input  wire logic [LEN_W-1:0] rem_i,
    input  wire logic [LEN_W-1:0] den_i,
    output logic                  done_o,
    output bicubic_pkg::frac_t    frac_o
);
    import bicubic_pkg::*;

    typedef logic [LEN_W-1:0] len_t;
    localparam int CNT_W = $clog2(FRAC_W + 2);

    logic [CNT_W-1:0] cnt;      // 0 idle, counts down from FRAC_W+1
    len_t             part;     // partial remainder, below den
    len_t             den_q;
    logic [LEN_W:0]   shifted;
    logic [LEN_W:0]   trial;
    logic             q_bit;

    always_comb begin
        shifted = {part, 1'b0};
        trial   = shifted - {1'b0, den_q};
        q_bit   = (shifted >= {1'b0, den_q});  // restore when it does not fit
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            cnt    <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= (cnt == CNT_W'(1));
            if (start_i) begin
                cnt <= CNT_W'(FRAC_W + 1);
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // one quotient bit per cycle, msb first
    always_ff @(posedge CLK) begin
        if (start_i) begin
            part  <= rem_i;
            den_q <= den_i;
        end else if (cnt > CNT_W'(1)) begin
            part   <= q_bit ? trial[LEN_W-1:0] : shifted[LEN_W-1:0];
            frac_o <= {frac_o[FRAC_W-2:0], q_bit};
        end
    end

    // controller must never hand over a zero divisor
    assert property (@(posedge CLK) disable iff (RST) start_i |-> den_i != '0)
        else $error("frac_divider: started with zero divisor");

endmodule

`default_nettype wire

// File: hw/position_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module position_ctrl #(
    parameter int LEN_W = bicubic_pkg::LEN_W
) (
    input  wire logic               CLK,
    input  wire logic               RST,
    input  wire logic               start_i,
    input  wire logic [LEN_W-1:0]   src_len_i,
    input  wire logic [LEN_W-1:0]   dst_len_i,
    input  wire logic               src_valid_i,
    input  wire bicubic_pkg::pix_t  src_pix_i,
    output logic                    src_ready_o,
    output logic                    div_start_o,
    output logic [LEN_W-1:0]        div_rem_o,
    output logic [LEN_W-1:0]        div_den_o,
    input  wire logic               div_done_i,
    input  wire bicubic_pkg::frac_t div_frac_i,
    output bicubic_pkg::cubic_req_t req_o,
    output logic                    req_valid_o,
    input  wire logic               req_ready_i,
    output logic                    last_issued_o
);
    import bicubic_pkg::*;

    typedef logic [LEN_W-1:0] len_t;

    ctrl_state_t    state;
    len_t           src_len_q;
    len_t           dst_len_q;
    len_t           q;          // integer part of source position
    len_t           r;          // remainder against dst_len-1
    len_t           in_cnt;     // source pixels taken so far
    len_t           out_cnt;    // outputs handed to the engine
    logic           div_pend;
    win_t           win;
    len_t           step;
    len_t           den;
    logic [LEN_W:0] acc_sum;
    logic           carry;
    logic           need_pix;
    logic           adv_go;
    logic           pix_fire;
    logic           fill_last;

    always_comb begin
        step      = src_len_q - 1'b1;
        den       = dst_len_q - 1'b1;
        acc_sum   = {1'b0, r} + {1'b0, step};
        carry     = (acc_sum >= {1'b0, den});     // q moves on
        need_pix  = carry && (in_cnt < src_len_q); // otherwise p3 repeats
        adv_go    = !need_pix || src_valid_i;
        pix_fire  = src_valid_i && src_ready_o;
        // three taps, or two when the source is that short
        fill_last = (in_cnt == len_t'(2)) || (in_cnt + 1'b1 == src_len_q);
    end

    assign src_ready_o   = (state == ST_FILL) || (state == ST_ADVANCE && need_pix);
    assign div_start_o   = (state == ST_DIVIDE) && !div_pend;
    assign div_rem_o     = r;
    assign div_den_o     = den;
    assign req_valid_o   = (state == ST_ISSUE);
    assign req_o         = '{win: win, frac: div_frac_i}; // divider holds its result
    assign last_issued_o = (state == ST_DONE);

    always_ff @(posedge CLK) begin
        if (RST) begin
            state    <= ST_IDLE;
            q        <= '0;
            r        <= '0;
            in_cnt   <= '0;
            out_cnt  <= '0;
            div_pend <= 1'b0;
        end else begin
            case (state)
                ST_IDLE, ST_DONE: begin
                    if (start_i) begin
                        q       <= '0;
                        r       <= '0;
                        in_cnt  <= '0;
                        out_cnt <= '0;
                        state   <= ST_FILL;
                    end
                end
                ST_FILL: begin
                    if (pix_fire) begin
                        in_cnt <= in_cnt + 1'b1;
                        if (fill_last) begin
                            state <= ST_DIVIDE;
                        end
                    end
                end
                ST_DIVIDE: begin
                    div_pend <= !div_done_i;  // set after the start cycle
                    if (div_done_i) begin
                        state <= ST_ISSUE;
                    end
                end
                ST_ISSUE: begin
                    if (req_ready_i) begin
                        out_cnt <= out_cnt + 1'b1;
                        state   <= (out_cnt == den) ? ST_DONE : ST_ADVANCE;
                    end
                end
                ST_ADVANCE: begin
                    if (adv_go) begin
                        if (carry) begin
                            q <= q + 1'b1;
                            r <= len_t'(acc_sum - {1'b0, den});
                        end else begin
                            r <= len_t'(acc_sum);  // window reused
                        end
                        if (need_pix) begin
                            in_cnt <= in_cnt + 1'b1;
                        end
                        state <= ST_DIVIDE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // lengths and window taps
    always_ff @(posedge CLK) begin
        if ((state == ST_IDLE || state == ST_DONE) && start_i) begin
            src_len_q <= src_len_i;
            dst_len_q <= dst_len_i;
        end
        if (state == ST_FILL && pix_fire) begin
            if (in_cnt == '0) begin
                // left edge clamps to src[0]
                win <= '{p0: src_pix_i, p1: src_pix_i, p2: src_pix_i, p3: src_pix_i};
            end else if (in_cnt == len_t'(1)) begin
                win.p2 <= src_pix_i;
                win.p3 <= src_pix_i;
            end else begin
                win.p3 <= src_pix_i;
            end
        end else if (state == ST_ADVANCE && carry && adv_go) begin
            win <= '{p0: win.p1, p1: win.p2, p2: win.p3,
                     p3: (need_pix ? src_pix_i : win.p3)};
        end
    end

    // accumulator must stay inside the source for the whole run
    assert property (@(posedge CLK) disable iff (RST)
        state != ST_IDLE |-> q < src_len_q)
        else $error("position_ctrl: q past last source pixel");

endmodule

`default_nettype wire

// File: sim/tb_bicubic.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bicubic #(
    parameter int TIMEOUT_EXTRA = 0   // extra cycles on top of the computed limit
);
    import bicubic_pkg::*;

    localparam int NUM_ROWS = 9;

    typedef struct packed {
        logic [LEN_W-1:0] src_len;
        logic [LEN_W-1:0] dst_len;
        logic [7:0]       gap;        // src_valid_i held off when draw is below
        logic [7:0]       stall;      // out_ready_i low when draw is below
    } row_t;

    logic             CLK;
    logic             RST;
    logic             start_i;
    logic [LEN_W-1:0] src_len_i;
    logic [LEN_W-1:0] dst_len_i;
    logic             src_valid_i;
    pix_t             src_pix_i;
    logic             src_ready_o;
    logic             out_valid_o;
    pix_t             out_pix_o;
    logic             out_ready_i;
    logic             done_o;

    int          pix_errors;
    int          count_errors;
    int          done_errors;
    row_t        rows [0:NUM_ROWS-1];
    pix_t        row_pix [0:(1<<LEN_W)-1];
    int unsigned lcg_state;

    bicubic_resampler #(.LEN_W(LEN_W)) dut (
        .CLK         (CLK),
        .RST         (RST),
        .start_i     (start_i),
        .src_len_i   (src_len_i),
        .dst_len_i   (dst_len_i),
        .src_valid_i (src_valid_i),
        .src_pix_i   (src_pix_i),
        .src_ready_o (src_ready_o),
        .out_valid_o (out_valid_o),
        .out_pix_o   (out_pix_o),
        .out_ready_i (out_ready_i),
        .done_o      (done_o)
    );

    tb_checker #(.LEN_W(LEN_W)) u_checker (
        .CLK          (CLK),
        .RST          (RST),
        .start_i      (start_i),
        .src_len_i    (src_len_i),
        .dst_len_i    (dst_len_i),
        .src_valid_i  (src_valid_i),
        .src_pix_i    (src_pix_i),
        .src_ready_o  (src_ready_o),
        .out_valid_o  (out_valid_o),
        .out_pix_o    (out_pix_o),
        .out_ready_i  (out_ready_i),
        .done_o       (done_o),
        .pix_errors   (pix_errors),
        .count_errors (count_errors),
        .done_errors  (done_errors)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // one byte from the upper bits of the generator
    function automatic int draw_byte();
        lcg_state = lcg_next(lcg_state);
        return int'((lcg_state >> 16) & 32'hff);
    endfunction

    task automatic report_counts();
        $display("errors: pixel %0d, count %0d, done %0d",
                 pix_errors, count_errors, done_errors);
    endtask

    // entered and left 1 ns after a rising edge
    task automatic run_row(input int row_idx);
        int   src_len;
        int   gap;
        int   stall;
        int   idx;
        int   i;
        logic fired;
        logic finished;
        src_len = int'(rows[row_idx].src_len);
        gap     = int'(rows[row_idx].gap);
        stall   = int'(rows[row_idx].stall);
        for (i = 0; i < src_len; i++) begin
            row_pix[i] = pix_t'(draw_byte());
        end
        start_i   = 1'b1;
        src_len_i = rows[row_idx].src_len;
        dst_len_i = rows[row_idx].dst_len;
        @(posedge CLK);
        #1;
        start_i  = 1'b0;
        idx      = 0;
        fired    = 1'b0;
        finished = 1'b0;
        while (!finished) begin
            if (fired) begin
                idx++;
                src_valid_i = 1'b0;
            end
            if (idx < src_len && !src_valid_i) begin
                if (draw_byte() >= gap) begin
                    src_valid_i = 1'b1;
                    src_pix_i   = row_pix[idx];
                end
            end
            out_ready_i = (draw_byte() >= stall);
            @(negedge CLK);                       // handshakes settled here
            fired    = src_valid_i && src_ready_o;
            finished = done_o;
            @(posedge CLK);
            #1;
        end
        src_valid_i = 1'b0;
        out_ready_i = 1'b1;
    endtask

    initial begin
        int r;
        RST           = 1'b1;
        start_i       = 1'b0;
        src_len_i     = '0;
        dst_len_i     = '0;
        src_valid_i   = 1'b0;
        src_pix_i     = '0;
        out_ready_i   = 1'b0;
        lcg_state     = 47;
        // src, dst, gap, stall
        rows[0] = '{7'd8,   7'd8,   8'd0,   8'd0};      // identity
        rows[1] = '{7'd17,  7'd28,  8'd0,   8'd0};
        rows[2] = '{7'd5,   7'd31,  8'd0,   8'd0};
        rows[3] = '{7'd2,   7'd9,   8'd0,   8'd0};      // padded window
        rows[4] = '{7'd17,  7'd28,  8'd0,   8'd128};    // output back-pressure
        rows[5] = '{7'd12,  7'd40,  8'd128, 8'd0};      // input gaps
        rows[6] = '{7'd5,   7'd31,  8'd96,  8'd160};
        rows[7] = '{7'd2,   7'd2,   8'd64,  8'd64};
        rows[8] = '{7'd127, 7'd127, 8'd32,  8'd32};
        repeat (3) @(posedge CLK);
        #1;
        RST = 1'b0;
        for (r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        repeat (4) @(posedge CLK);
        report_counts();
        if (pix_errors + count_errors + done_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // run limit of 20 cycles per output plus 200 per row
    initial begin
        int cycle_limit;
        int cycles;
        int i;
        @(posedge CLK);
        cycle_limit = 200 * NUM_ROWS + TIMEOUT_EXTRA;
        for (i = 0; i < NUM_ROWS; i++) begin
            cycle_limit += 20 * int'(rows[i].dst_len);
        end
        cycles = 1;
        while (cycles < cycle_limit) begin
            @(posedge CLK);
            cycles++;
        end
        $display("timeout: done_o never came, run stopped after %0d cycles", cycles);
        report_counts();
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker #(
    parameter int LEN_W = bicubic_pkg::LEN_W
) (
    input  wire logic              CLK,
    input  wire logic              RST,
    input  wire logic              start_i,
    input  wire logic [LEN_W-1:0]  src_len_i,
    input  wire logic [LEN_W-1:0]  dst_len_i,
    input  wire logic              src_valid_i,
    input  wire bicubic_pkg::pix_t src_pix_i,
    input  wire logic              src_ready_o,
    input  wire logic              out_valid_o,
    input  wire bicubic_pkg::pix_t out_pix_o,
    input  wire logic              out_ready_i,
    input  wire logic              done_o,
    output int                     pix_errors,
    output int                     count_errors,
    output int                     done_errors
);
    import bicubic_pkg::*;

    pix_t src_seen [0:(1<<LEN_W)-1];  // source pixels in arrival order
    int   src_len;
    int   dst_len;
    int   n_in;
    int   n_out;
    int   row;
    int   q_m;                        // integer part of model position
    int   r_m;                        // model remainder against dst_len-1
    int   frac;
    int   exp_pix;
    logic running;
    logic await_done;

    // den is always positive here
    function automatic int floor_div(input int num, input int den);
        int quo;
        quo = num / den;
        if (num < 0 && (num % den) != 0) begin
            quo = quo - 1;
        end
        return quo;
    endfunction

    // source pixel with the index clamped to the row
    function automatic int tap(input int idx);
        int k;
        k = idx;
        if (k < 0) begin
            k = 0;
        end
        if (k > src_len - 1) begin
            k = src_len - 1;
        end
        return int'(src_seen[k]);
    endfunction

    function automatic int catmull_rom(input int p0, input int p1, input int p2,
                                       input int p3, input int x);
        int a;
        int b;
        int c;
        int d;
        int s1;
        int s2;
        int s3;
        int res;
        a   = -p0 + 3 * p1 - 3 * p2 + p3;
        b   = 2 * p0 - 5 * p1 + 4 * p2 - p3;
        c   = p2 - p0;
        d   = 2 * p1;
        s1  = floor_div(a * x, 256);
        s2  = floor_div((s1 + b) * x, 256);
        s3  = floor_div((s2 + c) * x, 256);
        res = floor_div(s3 + d + 1, 2);
        if (res < 0) begin
            res = 0;
        end else if (res > 255) begin
            res = 255;
        end
        return res;
    endfunction

    initial begin
        pix_errors   = 0;
        count_errors = 0;
        done_errors  = 0;
        row          = -1;
        running      = 1'b0;
        await_done   = 1'b0;
    end

    // sampled mid-cycle away from the driving edge
    always @(negedge CLK) begin
        if (RST) begin
            running    = 1'b0;
            await_done = 1'b0;
        end else if (start_i) begin
            src_len    = int'(src_len_i);
            dst_len    = int'(dst_len_i);
            n_in       = 0;
            n_out      = 0;
            q_m        = 0;
            r_m        = 0;
            row++;
            running    = 1'b1;
            await_done = 1'b0;
        end else if (running) begin
            if (src_valid_i && src_ready_o) begin
                src_seen[n_in] = src_pix_i;
                n_in++;
            end
            if (await_done) begin
                if (!done_o) begin
                    done_errors++;
                    $display("ERROR t=%0t done_o row %0d: expected 1, got 0", $time, row);
                end
                await_done = 1'b0;
            end else if (done_o && n_out < dst_len) begin
                done_errors++;
                $display("ERROR t=%0t done_o row %0d: expected 0, got 1 after %0d of %0d",
                         $time, row, n_out, dst_len);
                running = 1'b0;   // row lost so stop following it
            end
            if (running && out_valid_o && out_ready_i) begin
                if (n_out >= dst_len) begin
                    count_errors++;
                    $display("row %0d: DUT sent an extra output pixel beyond %0d",
                             row, dst_len);
                end else begin
                    frac    = (r_m * 256) / (dst_len - 1);
                    exp_pix = catmull_rom(tap(q_m - 1), tap(q_m), tap(q_m + 1),
                                          tap(q_m + 2), frac);
                    if (int'(out_pix_o) != exp_pix) begin
                        pix_errors++;
                        $display("ERROR t=%0t out_pix_o row %0d pixel %0d: expected %0d, got %0d",
                                 $time, row, n_out, exp_pix, int'(out_pix_o));
                    end
                    r_m = r_m + src_len - 1;
                    if (r_m >= dst_len - 1) begin
                        r_m = r_m - (dst_len - 1);
                        q_m++;
                    end
                    n_out++;
                    if (n_out == dst_len) begin
                        await_done = 1'b1;
                        // every source pixel is in the window by the last output
                        if (n_in != src_len) begin
                            count_errors++;
                            $display("row %0d: DUT consumed %0d source pixels instead of %0d",
                                     row, n_in, src_len);
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire
